//--- sim.f
hdl/line_pkg.sv
hdl/frame_pkg.sv
hdl/reset_controller.sv
hdl/clk_enable_controller.sv
hdl/payload_generator.sv
hdl/coder_fsm.sv
hdl/frame_shifter.sv
hdl/coder.sv
hdl/umio_core.sv
testbench/umio_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing -f sim.f --top-module umio_core_tb -o umio_sim &&
./obj_dir/umio_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- testbench/umio_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module umio_core_tb;

	import line_pkg::*;
	import frame_pkg::*;

	localparam int HALF_CYC       = CLK_EN_DIV;
	localparam int DE_CYC         = FRAME_HALVES * CLK_EN_DIV;
	localparam int GAP_CYC        = GAP_HALVES * CLK_EN_DIV;
	localparam int MIN_SPACE      = (FRAME_HALVES + GAP_HALVES) * CLK_EN_DIV;
	localparam int FRAME_CYC      = (FRAME_HALVES + GAP_HALVES + 2) * CLK_EN_DIV;
	localparam int N_TOGGLES      = 6;
	localparam int MAX_HOLD       = 400;
	localparam int PLANNED_FRAMES = 4 + N_TOGGLES + 3 + 2;
	localparam int RUN_OFF_CYC    = N_TOGGLES * 2 * MAX_HOLD;
	localparam int MARGIN_CYC     = 16 + RST_HOLD + 400;
	localparam int LIMIT_CYC      = PLANNED_FRAMES * FRAME_CYC + RUN_OFF_CYC + MARGIN_CYC;

	logic clk;
	logic arst_n;
	logic run;
	logic line;
	logic line_de;
	logic busy;

	logic [31:0] lcg_state;
	int          checks;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_errors;
	int          frames_done;

	// Line decoder and reference model state
	logic                    in_frame;
	logic                    prev_de;
	logic                    started;
	logic                    have_start;
	logic                    first_after_rst;
	int                      cyc;
	int                      cycle_no;
	int                      last_start;
	int                      run_low_cnt;
	logic [FRAME_HALVES-1:0] halves;
	logic [FRAME_W-1:0]      bits;
	logic [DATA_W-1:0]       model_lfsr;
	logic [DATA_W-1:0]       byte_after_rst;

	umio_core UUT (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.line(line),
		.line_de(line_de),
		.busy(busy)
	);

	always #20 clk = ~clk;

	function automatic int unsigned rand_upto(input int unsigned max);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return (lcg_state >> 8) % (max + 1);
	endfunction

	// Left-shifting register for x^8+x^6+x^5+x^4+1 with the new bit at bit 0
	function automatic logic [DATA_W-1:0] lfsr_step(input logic [DATA_W-1:0] q);
		return {q[DATA_W-2:0], q[7] ^ q[5] ^ q[4] ^ q[3]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
		end
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors > test_errors) begin
			tests_failed++;
			$display("Test %0d %s: FAIL, %0d errors", tests_run, name, errors - test_errors);
		end else begin
			$display("Test %0d %s: PASS", tests_run, name);
		end
	endtask

	task automatic decode_frame();
		logic [DATA_W-1:0] data;
		int                i;
		for (i = 0; i < FRAME_W; i++) begin
			check_value("half-bit pair complementary", 32'(halves[2*i+1] ^ 1'b1),
				32'(halves[2*i]));
			bits[i] = halves[2*i+1];
		end
		data = bits[DATA_W:1];
		check_value("start bit", 0, 32'(bits[0]));
		check_value("stop bit", 1, 32'(bits[FRAME_W-1]));
		check_value("even parity bit", 32'(^data), 32'(bits[DATA_W+1]));
		check_value("payload byte", 32'(model_lfsr), 32'(data));
		if (first_after_rst) begin
			byte_after_rst  = data;
			first_after_rst = 1'b0;
		end
		model_lfsr = lfsr_step(model_lfsr);
		frames_done++;
	endtask

	// One sample per clock cycle of an active frame and its gap
	task automatic track_frame();
		if (cyc < DE_CYC) begin
			check_value("line_de inside frame", 1, 32'(line_de));
			check_value("busy inside frame", 1, 32'(busy));
			if (cyc % HALF_CYC == 0) begin
				halves[cyc / HALF_CYC] = line;
			end else begin
				check_value("line steady within half-bit", 32'(halves[cyc / HALF_CYC]),
					32'(line));
			end
		end else begin
			check_value("line_de after frame", 0, 32'(line_de));
			check_value("line after frame", 0, 32'(line));
			if (cyc == DE_CYC) begin
				decode_frame();
			end
			if (cyc < DE_CYC + GAP_CYC - 1) begin
				check_value("busy during gap", 1, 32'(busy));
			end else begin
				check_value("busy after gap", 0, 32'(busy));
				in_frame = 1'b0;
			end
		end
		cyc++;
	endtask

	// Outputs are read at the rising edge, before the DUT updates them
	always @(posedge clk) begin
		cycle_no++;
		if (!arst_n) begin
			check_value("line in reset", 0, 32'(line));
			check_value("line_de in reset", 0, 32'(line_de));
			check_value("busy in reset", 0, 32'(busy));
			in_frame        = 1'b0;
			prev_de         = 1'b0;
			started         = 1'b0;
			have_start      = 1'b0;
			first_after_rst = 1'b1;
			model_lfsr      = LFSR_SEED;
			run_low_cnt     = 0;
		end else begin
			if (!started) begin
				check_value("line before first frame", 0, 32'(line));
				check_value("line_de before first frame", 0, 32'(line_de));
				check_value("busy before first frame", 0, 32'(busy));
			end
			if (!in_frame && line_de && !prev_de) begin
				// A frame may only follow a strobe that saw run high
				check_value("frame start with run low", 1,
					32'(run_low_cnt <= CLK_EN_DIV + 1));
				if (have_start) begin
					check_value("frame start spacing", 1,
						32'(cycle_no - last_start >= MIN_SPACE));
				end
				have_start = 1'b1;
				last_start = cycle_no;
				in_frame   = 1'b1;
				cyc        = 0;
				halves     = '0;
			end
			if (in_frame) begin
				track_frame();
			end else if (!line_de) begin
				check_value("idle line", 0, 32'(line));
			end
			prev_de = line_de;
			if (run) begin
				started     = 1'b1;
				run_low_cnt = 0;
			end else begin
				run_low_cnt++;
			end
		end
	end

	task automatic wait_frames(input int n);
		int target;
		target = frames_done + n;
		while (frames_done < target) begin
			@(negedge clk);
		end
	endtask

	initial begin
		clk             = 1'b0;
		arst_n          = 1'b0;
		run             = 1'b0;
		lcg_state       = 32'h3033_525a;
		checks          = 0;
		errors          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		frames_done     = 0;
		cycle_no        = 0;
		last_start      = 0;
		run_low_cnt     = 0;
		cyc             = 0;
		in_frame        = 1'b0;
		prev_de         = 1'b0;
		started         = 1'b0;
		have_start      = 1'b0;
		first_after_rst = 1'b1;
		model_lfsr      = LFSR_SEED;
		byte_after_rst  = '0;

		start_test();
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		repeat (RST_HOLD + 2 + 4 * CLK_EN_DIV) @(negedge clk);
		finish_test("reset values");

		start_test();
		run = 1'b1;
		wait_frames(4);
		finish_test("payload sequence and frame format");

		// Random on and off times so run often falls inside a frame
		start_test();
		for (int i = 0; i < N_TOGGLES; i++) begin
			run = 1'b1;
			repeat (rand_upto(MAX_HOLD)) @(negedge clk);
			run = 1'b0;
			repeat (rand_upto(MAX_HOLD)) @(negedge clk);
		end
		finish_test("run control");

		start_test();
		run = 1'b1;
		wait (line_de === 1'b0);
		wait (line_de === 1'b1);
		@(negedge clk);
		repeat (rand_upto(DE_CYC / 2)) @(negedge clk);
		arst_n = 1'b0;
		#1;
		check_value("line right after reset", 0, 32'(line));
		check_value("line_de right after reset", 0, 32'(line_de));
		check_value("busy right after reset", 0, 32'(busy));
		repeat (1 + rand_upto(3)) @(negedge clk);
		arst_n = 1'b1;
		wait_frames(3);
		check_value("first byte after reset", 32'(LFSR_SEED), 32'(byte_after_rst));
		finish_test("mid-run reset");

		// Line must stay quiet once the last frame has drained
		start_test();
		run = 1'b0;
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
		repeat (2 * FRAME_CYC) begin
			@(negedge clk);
			check_value("busy with run low", 0, 32'(busy));
		end
		finish_test("run stop");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d, frames %0d",
			tests_run, tests_failed, checks, errors, frames_done);
		if (errors == 0 && tests_failed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Limit follows from the planned frames and the longest run-off time
	initial begin
		repeat (LIMIT_CYC) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYC);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/umio_core.sv
`timescale 1ns/1ps
`default_nettype none

module umio_core (
	input  logic clk,
	input  logic arst_n,
	input  logic run,
	output logic line,
	output logic line_de,
	output logic busy
);

	import frame_pkg::*;

	logic              n_rst;
	logic              clk_en;
	logic [DATA_W-1:0] pg_q_cd_d;
	logic              pg_pl_rdy_cd_wr_en;

	reset_controller rst_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.n_rst(n_rst)
	);

	clk_enable_controller clk_en_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.clk_en(clk_en)
	);

	// Busy from the coder is the back-pressure for the generator
	payload_generator pl_gen (
		.clk(clk),
		.n_rst(n_rst),
		.clk_en(clk_en),
		.run(run),
		.cd_busy(busy),
		.q(pg_q_cd_d),
		.pl_rdy(pg_pl_rdy_cd_wr_en)
	);

	coder cd (
		.clk(clk),
		.n_rst(n_rst),
		.clk_en(clk_en),
		.d(pg_q_cd_d),
		.wr_en(pg_pl_rdy_cd_wr_en),
		.busy(busy),
		.line(line),
		.line_de(line_de)
	);

endmodule

`default_nettype wire

//--- hdl/coder.sv
`timescale 1ns/1ps
`default_nettype none

module coder (
	input  logic                        clk,
	input  logic                        n_rst,
	input  logic                        clk_en,
	input  logic [frame_pkg::DATA_W-1:0] d,
	input  logic                        wr_en,
	output logic                        busy,
	output logic                        line,
	output logic                        line_de
);

	logic load;
	logic shift;
	logic half;
	logic de;

	coder_fsm fsm (
		.clk(clk),
		.n_rst(n_rst),
		.clk_en(clk_en),
		.wr_en(wr_en),
		.load(load),
		.shift(shift),
		.half(half),
		.de(de),
		.busy(busy)
	);

	frame_shifter shifter (
		.clk(clk),
		.n_rst(n_rst),
		.d(d),
		.load(load),
		.shift(shift),
		.half(half),
		.de(de),
		.line(line)
	);

	// Line is registered in the shifter
	// Delay the driver enable by the same cycle so both edges coincide
	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			line_de <= 1'b0;
		end else begin
			line_de <= de;
		end
	end

endmodule

`default_nettype wire

//--- hdl/frame_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_shifter (
	input  logic                        clk,
	input  logic                        n_rst,
	input  logic [frame_pkg::DATA_W-1:0] d,
	input  logic                        load,
	input  logic                        shift,
	input  logic                        half,
	input  logic                        de,
	output logic                        line
);

	import frame_pkg::*;

	logic [FRAME_W-1:0] frame;
	logic               head;
	logic               parity;

	// Even parity over the data byte
	assign parity = ^d;

	// Bit on the line is always the LSB of the frame register
	assign head = frame[0];

	// Frame layout from LSB: start 0, data LSB first, parity, stop 1
	// Ones are shifted in behind the stop bit
	always_ff @(posedge clk) begin
		if (load) begin
			frame <= {1'b1, parity, d, 1'b0};
		end else if (shift) begin
			frame <= {1'b1, frame[FRAME_W-1:1]};
		end
	end

	// Manchester: inverted bit in the first half, true bit in the second
	// Line is parked low whenever the driver is off
	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			line <= 1'b0;
		end else begin
			line <= de & (half ? head : ~head);
		end
	end

endmodule

`default_nettype wire

//--- hdl/coder_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module coder_fsm (
	input  logic clk,
	input  logic n_rst,
	input  logic clk_en,
	input  logic wr_en,
	output logic load,
	output logic shift,
	output logic half,
	output logic de,
	output logic busy
);

	import line_pkg::*;
	import frame_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_EDGE,
		SEND,
		GAP
	} state_t;

	state_t               state;
	logic [BIT_CNT_W-1:0] half_cnt;
	logic                 last_half;
	logic                 last_gap;

	assign last_half = (half_cnt == BIT_CNT_W'(FRAME_HALVES - 1));
	assign last_gap  = (half_cnt == BIT_CNT_W'(GAP_HALVES - 1));

	// One counter serves both the half-bits of the frame and the gap strobes
	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			state    <= IDLE;
			half_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (wr_en) begin
						state <= WAIT_EDGE;
					end
				end
				// Line starts on a strobe so every half-bit is a full period
				WAIT_EDGE: begin
					if (clk_en) begin
						state    <= SEND;
						half_cnt <= '0;
					end
				end
				SEND: begin
					if (clk_en) begin
						if (last_half) begin
							state    <= GAP;
							half_cnt <= '0;
						end else begin
							half_cnt <= half_cnt + 1'b1;
						end
					end
				end
				GAP: begin
					if (clk_en) begin
						if (last_gap) begin
							state <= IDLE;
						end else begin
							half_cnt <= half_cnt + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Byte is captured in the wr_en cycle while d is still valid
	assign load  = (state == IDLE) & wr_en;
	// Advance after the second half of each bit
	assign shift = (state == SEND) & clk_en & half_cnt[0];
	assign half  = half_cnt[0];
	assign de    = (state == SEND);
	assign busy  = (state != IDLE);

endmodule

`default_nettype wire

//--- hdl/payload_generator.sv
`timescale 1ns/1ps
`default_nettype none

module payload_generator (
	input  logic                        clk,
	input  logic                        n_rst,
	input  logic                        clk_en,
	input  logic                        run,
	input  logic                        cd_busy,
	output logic [frame_pkg::DATA_W-1:0] q,
	output logic                        pl_rdy
);

	import frame_pkg::*;

	logic feedback;

	// Offer a byte only on a strobe when the coder is free
	// The coder raises busy on the next clock, so a second pulse
	// can not follow before the frame is done
	assign pl_rdy = clk_en & run & ~cd_busy;

	// Fibonacci feedback over the tapped bits
	assign feedback = ^(q & LFSR_TAPS);

	// q is the LFSR itself
	// It holds while run is low or the coder is busy,
	// so no value is lost across run toggles
	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			q <= LFSR_SEED;
		end else if (pl_rdy) begin
			// Step once per accepted byte, new bit enters at bit 0
			q <= {q[DATA_W-2:0], feedback};
		end
	end

endmodule

`default_nettype wire

//--- hdl/clk_enable_controller.sv
`timescale 1ns/1ps
`default_nettype none

module clk_enable_controller (
	input  logic clk,
	input  logic n_rst,
	output logic clk_en
);

	import line_pkg::*;

	logic [DIV_W-1:0] div_cnt;
	logic             div_last;

	// Terminal count of the divider
	assign div_last = (div_cnt == DIV_W'(CLK_EN_DIV - 1));

	// Free-running divider, the strobe is registered
	// so the first pulse lands CLK_EN_DIV cycles after reset release
	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			div_cnt <= '0;
			clk_en  <= 1'b0;
		end else begin
			clk_en <= div_last;
			if (div_last) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/reset_controller.sv
`timescale 1ns/1ps
`default_nettype none

module reset_controller (
	input  logic clk,
	input  logic arst_n,
	output logic n_rst
);

	import line_pkg::*;

	logic [1:0]        sync;
	logic [HOLD_W-1:0] hold_cnt;

	// Assertion is immediate, release goes through two flops and the hold count
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync     <= 2'b00;
			hold_cnt <= '0;
			n_rst    <= 1'b0;
		end else begin
			sync <= {sync[0], 1'b1};
			if (sync[1] && !n_rst) begin
				// Release on the last count
				if (hold_cnt == HOLD_W'(RST_HOLD - 1)) begin
					n_rst <= 1'b1;
				end else begin
					hold_cnt <= hold_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/frame_pkg.sv
`default_nettype none

package frame_pkg;

	// Payload byte
	localparam int DATA_W = 8;

	// Start bit, data, even parity and stop bit
	localparam int FRAME_W = DATA_W + 3;

	// Two Manchester halves per frame bit
	localparam int FRAME_HALVES = 2 * FRAME_W;

	// Half-bit counter width, also reused for the gap count
	localparam int BIT_CNT_W = $clog2(FRAME_HALVES);

	// First byte sent after reset
	localparam logic [DATA_W-1:0] LFSR_SEED = 8'h01;

	// x^8 + x^6 + x^5 + x^4 + 1 as a mask over bits 7, 5, 4 and 3
	localparam logic [DATA_W-1:0] LFSR_TAPS = 8'hb8;

endpackage

`default_nettype wire

//--- hdl/line_pkg.sv
`default_nettype none

package line_pkg;

	// Main clock cycles per half-bit of the line code
	localparam int CLK_EN_DIV = 4;

	// Cycles the internal reset stays low once the synchronizer has released
	localparam int RST_HOLD = 8;

	// Idle half-bits between the stop bit and the next possible frame
	localparam int GAP_HALVES = 4;

	// Divider counter width
	localparam int DIV_W = (CLK_EN_DIV > 1) ? $clog2(CLK_EN_DIV) : 1;

	// Hold counter width
	localparam int HOLD_W = $clog2(RST_HOLD + 1);

endpackage

`default_nettype wire
